/* src/poly_cmd_pkg.sv */
/*
   Input token encoding for the polynomial engine.
   A token is either a command header or a 16-bit unsigned operand value.
   Opcodes outside op_stp, op_evp and op_rst are illegal and get st_bad_op.
*/
package poly_cmd_pkg;

   localparam int word_w = 16;   // token width
   localparam int op_w   = 8;    // opcode field width
   localparam int slot_w = 3;    // slot field width, A
   localparam int deg_w  = 5;    // degree field width, N

   // instruction codes keep the legacy numbering, code 2 is no longer used
   typedef enum logic [op_w-1:0]
   {
      op_stp = 8'd0,
      op_evp = 8'd1,
      op_rst = 8'd3
   } opcode_t;

   // header layout from the msb down
   typedef struct packed
   {
      logic [deg_w-1:0]  degree;   // N, may exceed the supported maximum
      logic [slot_w-1:0] slot;     // A
      opcode_t           opcode;
   } cmd_header_t;

   // the same 16 bits read either as a header or as an operand
   typedef union packed
   {
      cmd_header_t       hdr;
      logic [word_w-1:0] value;
   } token_u;

   typedef enum logic [1:0]
   {
      st_ok         = 2'd0,
      st_bad_op     = 2'd1,
      st_bad_degree = 2'd2,
      st_empty_slot = 2'd3
   } status_e;

endpackage

/* src/poly_pipe_pkg.sv */
/*
   Pipeline types shared by the parser, coefficient bank and evaluator.
   Coefficients and x are unsigned 16 bits, results wrap modulo 2^32.
   Degree is limited to max_degree, so a slot holds max_degree+1 coefficients.
*/
package poly_pipe_pkg;

   import poly_cmd_pkg::*;

   localparam int num_slots  = 8;
   localparam int max_degree = 7;
   localparam int idx_w      = $clog2(max_degree + 1);   // coefficient index width
   localparam int result_w   = 32;
   localparam int stat_pad_w = result_w - 2 - deg_w - slot_w - op_w;

   typedef logic [max_degree:0][word_w-1:0] coef_vec_t;

   // one parsed command
   typedef struct packed
   {
      opcode_t           opcode;
      logic [slot_w-1:0] slot;
      logic [deg_w-1:0]  degree;
      coef_vec_t         operands;   // for EVP element 0 holds x
      status_e           err;
   } job_t;

   // job plus the coefficients read from the bank
   typedef struct packed
   {
      job_t      job;
      coef_vec_t coefs;
   } eval_job_t;

   // status word is {pad, err, degree, slot, opcode} from the msb down
   typedef struct packed
   {
      logic [result_w-1:0] result;
      logic [result_w-1:0] status;
   } out_pkt_t;

endpackage

/* src/cmd_parser.sv */
/*
   Stage 1. Turns the token stream into one job per command.
   One token per cycle is accepted while no job is held. The job is valid
   the cycle after its last token, and tok_ready stays low until it leaves.
   STP with N > max_degree and illegal opcodes consume no operand tokens.
*/
`timescale 1ns/10ps
module cmd_parser
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   tok_valid,
   input  token_u tok,
   output logic   tok_ready,
   output logic   job_valid,
   output job_t   job,
   input  logic   job_ready
);

   typedef enum logic [1:0] {s_idle, s_collect, s_hold} state_e;

   state_e           state;
   job_t             job_q;
   logic [idx_w-1:0] idx;        // next operand position
   logic [idx_w-1:0] last_idx;   // position of the final operand
   logic [idx_w:0]   n_ops;      // operand count of the header, 0 to 8
   status_e          hdr_err;
   logic             tok_take;

   assign tok_ready = (state != s_hold);
   assign job_valid = (state == s_hold);
   assign job       = job_q;
   assign tok_take  = tok_valid && tok_ready;

   // header decode, only meaningful while idle
   always_comb
   begin
      hdr_err = st_ok;
      n_ops   = '0;
      case (tok.hdr.opcode)
         op_stp:
         begin
            if (tok.hdr.degree <= deg_w'(max_degree))
               n_ops = (idx_w+1)'(tok.hdr.degree) + 1'b1;   // c_0 up to c_N
            else
               hdr_err = st_bad_degree;
         end
         op_evp:
         begin
            n_ops = 1;   // just x
         end
         op_rst:
         begin
            n_ops = '0;
         end
         default:
         begin
            hdr_err = st_bad_op;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state    <= s_idle;
         idx      <= '0;
         last_idx <= '0;
      end
      else
      begin
         case (state)
            s_idle:
            begin
               if (tok_take)
               begin
                  idx      <= '0;
                  last_idx <= idx_w'(n_ops - 1'b1);
                  state    <= (n_ops == 0) ? s_hold : s_collect;
               end
            end
            s_collect:
            begin
               if (tok_take)
               begin
                  if (idx == last_idx)
                     state <= s_hold;
                  else
                     idx <= idx + 1'b1;
               end
            end
            default:
            begin
               if (job_ready)
                  state <= s_idle;   // job handed to the bank
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == s_idle && tok_take)
      begin
         job_q.opcode <= tok.hdr.opcode;
         job_q.slot   <= tok.hdr.slot;
         job_q.degree <= tok.hdr.degree;
         job_q.err    <= hdr_err;
      end
      else if (state == s_collect && tok_take)
      begin
         job_q.operands[idx] <= tok.value;
      end
   end

endmodule

/* src/coef_bank.sv */
/*
   Stage 2. Holds num_slots coefficient sets with their degree and valid flag.
   STP and RST take effect on the edge that accepts the job, so a following
   EVP always sees them. ev_valid rises one cycle after a job is accepted.
   Coefficients above the stored degree are don't care.
*/
`timescale 1ns/10ps
module coef_bank
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      job_valid,
   input  job_t      job,
   output logic      job_ready,
   output logic      ev_valid,
   output eval_job_t ev,
   input  logic      ev_ready
);

   coef_vec_t            coef_mem [num_slots];
   logic [idx_w-1:0]     deg_mem  [num_slots];
   logic [num_slots-1:0] slot_vld;   // slot has been stored since the last RST
   logic                 job_take;
   logic                 stp_ok;

   assign job_ready = !ev_valid || ev_ready;   // a held job stalls the parser
   assign job_take  = job_valid && job_ready;
   assign stp_ok    = (job.opcode == op_stp) && (job.err == st_ok);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         ev_valid <= 1'b0;
         slot_vld <= '0;
      end
      else
      begin
         if (job_take)
         begin
            ev_valid <= 1'b1;
            if (stp_ok)
               slot_vld[job.slot] <= 1'b1;
            else if (job.opcode == op_rst)
               slot_vld <= '0;   // empties every slot at once
         end
         else if (ev_ready)
         begin
            ev_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (job_take && stp_ok)
      begin
         coef_mem[job.slot] <= job.operands;
         deg_mem[job.slot]  <= job.degree[idx_w-1:0];
      end
   end

   // outgoing job, EVP picks up the stored degree and coefficients
   always_ff @(posedge clk)
   begin
      if (job_take)
      begin
         ev.job   <= job;
         ev.coefs <= coef_mem[job.slot];
         if (job.opcode == op_evp)
         begin
            if (slot_vld[job.slot])
               ev.job.degree <= deg_w'(deg_mem[job.slot]);
            else
               ev.job.err <= st_empty_slot;
         end
      end
   end

endmodule

/* src/horner_eval.sv */
/*
   Stage 3. Horner evaluation, acc = acc*x + c_i from c_N down to c_0.
   A good EVP gives out_valid degree+1 cycles after acceptance, every other
   job gives it after one cycle with result zero. Accepts a new job only
   when idle, so a held packet stalls the bank.
*/
`timescale 1ns/10ps
module horner_eval
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      ev_valid,
   input  eval_job_t ev,
   output logic      ev_ready,
   output logic      out_valid,
   output out_pkt_t  out,
   input  logic      out_ready
);

   typedef enum logic [1:0] {s_idle, s_run, s_done} state_e;

   state_e              state;
   eval_job_t           ev_q;
   logic [result_w-1:0] acc;
   logic [result_w-1:0] x_ext;
   logic [idx_w-1:0]    step;   // index of the coefficient folded in last
   logic                ev_take;
   logic                good_evp;

   assign ev_ready  = (state == s_idle);
   assign out_valid = (state == s_done);
   assign ev_take   = ev_valid && ev_ready;
   assign good_evp  = (ev.job.opcode == op_evp) && (ev.job.err == st_ok);
   assign x_ext     = result_w'(ev_q.job.operands[0]);

   assign out.result = acc;
   assign out.status = {stat_pad_w'(0), ev_q.job.err, ev_q.job.degree,
                        ev_q.job.slot, ev_q.job.opcode};

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state <= s_idle;
         step  <= '0;
      end
      else
      begin
         case (state)
            s_idle:
            begin
               if (ev_take)
               begin
                  step  <= ev.job.degree[idx_w-1:0];
                  state <= (good_evp && ev.job.degree != 0) ? s_run : s_done;
               end
            end
            s_run:
            begin
               step <= step - 1'b1;
               if (step == 1)
                  state <= s_done;   // c_0 goes in on this edge
            end
            default:
            begin
               if (out_ready)
                  state <= s_idle;
            end
         endcase
      end
   end

   // the first step uses acc = 0, so it just loads c_N
   always_ff @(posedge clk)
   begin
      if (ev_take)
      begin
         ev_q <= ev;
         acc  <= good_evp ? result_w'(ev.coefs[ev.job.degree[idx_w-1:0]]) : '0;
      end
      else if (state == s_run)
      begin
         acc <= acc * x_ext + result_w'(ev_q.coefs[step - 1'b1]);   // wraps mod 2^32
      end
   end

endmodule

/* src/poly_engine.sv */
/*
   Polynomial engine top level, parser to coefficient bank to evaluator.
   Every link is valid/ready. Up to three commands are in flight and
   back-pressure on out_ready stalls the stages in turn.
*/
`timescale 1ns/10ps
module poly_engine
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     tok_valid,
   input  token_u   tok,
   output logic     tok_ready,
   output logic     out_valid,
   output out_pkt_t out,
   input  logic     out_ready
);

   logic      job_valid;
   logic      job_ready;
   job_t      job;
   logic      ev_valid;
   logic      ev_ready;
   eval_job_t ev;

   cmd_parser parser_i
   (
      .clk       (clk),
      .rst       (rst),
      .tok_valid (tok_valid),
      .tok       (tok),
      .tok_ready (tok_ready),
      .job_valid (job_valid),
      .job       (job),
      .job_ready (job_ready)
   );

   coef_bank bank_i
   (
      .clk       (clk),
      .rst       (rst),
      .job_valid (job_valid),
      .job       (job),
      .job_ready (job_ready),
      .ev_valid  (ev_valid),
      .ev        (ev),
      .ev_ready  (ev_ready)
   );

   horner_eval eval_i
   (
      .clk       (clk),
      .rst       (rst),
      .ev_valid  (ev_valid),
      .ev        (ev),
      .ev_ready  (ev_ready),
      .out_valid (out_valid),
      .out       (out),
      .out_ready (out_ready)
   );

endmodule

/* dv/poly_engine_assert.sv */
/*
   Protocol checks for poly_engine, bound to every instance of it.
   Valid and data must hold on both handshakes while stalled, the outputs
   sit idle through reset, and a legal opcode never reports st_bad_op.
*/
`timescale 1ns/10ps
module poly_engine_assert
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
(
   input logic     clk,
   input logic     rst,
   input logic     tok_valid,
   input token_u   tok,
   input logic     tok_ready,
   input logic     out_valid,
   input out_pkt_t out,
   input logic     out_ready
);

   localparam int err_lsb = op_w + slot_w + deg_w;   // err sits just above degree

   logic [op_w-1:0] st_opcode;
   logic [1:0]      st_err;
   logic            legal_op;

   assign st_opcode = out.status[op_w-1:0];
   assign st_err    = out.status[err_lsb +: 2];
   assign legal_op  = (st_opcode == op_stp) || (st_opcode == op_evp) || (st_opcode == op_rst);

   reset_idle_a: assert property (@(posedge clk) (!rst) |-> (!out_valid && tok_ready))
      else $error("out_valid high or tok_ready low during reset");

   release_idle_a: assert property (@(posedge clk) $rose(rst) |-> (!out_valid && tok_ready))
      else $error("out_valid high or tok_ready low right after reset");

   out_hold_a: assert property (@(posedge clk) disable iff (!rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out)))
      else $error("output packet changed or dropped while stalled");

   tok_hold_a: assert property (@(posedge clk) disable iff (!rst)
      (tok_valid && !tok_ready) |=> (tok_valid && $stable(tok.value)))
      else $error("token changed or dropped while stalled");

   legal_status_a: assert property (@(posedge clk) disable iff (!rst)
      (out_valid && legal_op) |-> (st_err != 2'(st_bad_op)))
      else $error("st_bad_op reported for a legal opcode");

endmodule

bind poly_engine poly_engine_assert assert_i
(
   .clk       (clk),
   .rst       (rst),
   .tok_valid (tok_valid),
   .tok       (tok),
   .tok_ready (tok_ready),
   .out_valid (out_valid),
   .out       (out),
   .out_ready (out_ready)
);

/* dv/poly_engine_tb.sv */
/*
   Testbench for poly_engine. Random commands enter through the token port
   while out_ready stalls at random. Each packet is checked in order against
   a model of the slot contents. Two seed variables keep each run repeatable.
*/
`timescale 1ns/10ps
module poly_engine_tb
   import poly_cmd_pkg::*, poly_pipe_pkg::*;
();

   localparam int wait_limit  = 2000;   // cycles any single wait may take
   localparam int random_cmds = 60;

   logic     clk;
   logic     rst;
   logic     tok_valid;
   token_u   tok;
   logic     tok_ready;
   logic     out_valid;
   out_pkt_t out;
   logic     out_ready;

   integer      seed;          // command stream
   integer      stall_seed;    // out_ready pattern
   logic [31:0] stall_bits;
   int          errors  = 0;
   int          checked = 0;
   logic        hung;

   logic [word_w-1:0]    model_coef [num_slots][max_degree+1];
   logic [idx_w-1:0]     model_deg  [num_slots];
   logic [num_slots-1:0] model_vld;
   out_pkt_t             exp_q [$];

   poly_engine dut_i
   (
      .clk       (clk),
      .rst       (rst),
      .tok_valid (tok_valid),
      .tok       (tok),
      .tok_ready (tok_ready),
      .out_valid (out_valid),
      .out       (out),
      .out_ready (out_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % 32'(n));
   endfunction

   // header layout is {degree, slot, opcode} from the msb down
   function automatic logic [word_w-1:0] header_word(input logic [op_w-1:0] op,
         input logic [slot_w-1:0] slot, input logic [deg_w-1:0] degree);
      return {degree, slot, op};
   endfunction

   function automatic logic [result_w-1:0] pack_status(input logic [1:0] err,
         input logic [deg_w-1:0] degree, input logic [slot_w-1:0] slot,
         input logic [op_w-1:0] op);
      return {stat_pad_w'(0), err, degree, slot, op};
   endfunction

   // direct sum of c_i * x^i, wrapping at 32 bits
   function automatic logic [result_w-1:0] expected_sum(input int slot,
         input logic [word_w-1:0] x);
      logic [result_w-1:0] sum;
      logic [result_w-1:0] power;
      int                  i;
      sum   = '0;
      power = 1;
      for (i = 0; i <= int'(model_deg[slot]); i++)
      begin
         sum   = sum + power * result_w'(model_coef[slot][i]);
         power = power * result_w'(x);
      end
      return sum;
   endfunction

   task automatic expect_packet(input logic [result_w-1:0] result,
         input logic [result_w-1:0] status);
      out_pkt_t pkt;
      pkt.result = result;
      pkt.status = status;
      exp_q.push_back(pkt);
   endtask

   // holds the token until tok_ready is seen, the transfer is the next rising edge
   task automatic push_token(input logic [word_w-1:0] value);
      int waited;
      if (!hung)
      begin
         @(negedge clk);
         tok_valid = 1'b1;
         tok.value = value;
         waited    = 0;
         while (!tok_ready && waited < wait_limit)
         begin
            @(negedge clk);
            waited++;
         end
         if (!tok_ready)
         begin
            $display("timeout at %0t ns, tok_ready stayed low for %0d cycles", $time, waited);
            hung = 1'b1;
         end
      end
   endtask

   task automatic pause_tokens(input int cycles);
      int i;
      for (i = 0; i < cycles; i++)
      begin
         @(negedge clk);
         tok_valid = 1'b0;
      end
   endtask

   task automatic store_poly(input int slot, input int n);
      logic [word_w-1:0] c;
      int                i;
      if (n <= max_degree)
      begin
         expect_packet('0, pack_status(st_ok, deg_w'(n), slot_w'(slot), op_stp));
         push_token(header_word(op_stp, slot_w'(slot), deg_w'(n)));
         model_vld[slot] = 1'b1;
         model_deg[slot] = idx_w'(n);
         for (i = 0; i <= n; i++)
         begin
            c = word_w'(rand_below(65536));
            model_coef[slot][i] = c;
            push_token(c);
         end
      end
      else
      begin
         expect_packet('0, pack_status(st_bad_degree, deg_w'(n), slot_w'(slot), op_stp));
         push_token(header_word(op_stp, slot_w'(slot), deg_w'(n)));   // no operands follow
      end
   endtask

   // the header degree of an EVP is ignored unless the slot is empty
   task automatic eval_poly(input int slot, input logic [word_w-1:0] x);
      logic [deg_w-1:0] hdr_deg;
      hdr_deg = deg_w'(rand_below(32));
      if (model_vld[slot])
         expect_packet(expected_sum(slot, x),
                       pack_status(st_ok, deg_w'(model_deg[slot]), slot_w'(slot), op_evp));
      else
         expect_packet('0, pack_status(st_empty_slot, hdr_deg, slot_w'(slot), op_evp));
      push_token(header_word(op_evp, slot_w'(slot), hdr_deg));
      push_token(x);
   endtask

   task automatic clear_slots();
      logic [slot_w-1:0] slot;
      logic [deg_w-1:0]  degree;
      slot      = slot_w'(rand_below(num_slots));
      degree    = deg_w'(rand_below(32));
      model_vld = '0;
      expect_packet('0, pack_status(st_ok, degree, slot, op_rst));
      push_token(header_word(op_rst, slot, degree));
   endtask

   task automatic issue_bad_opcode(input int op);
      logic [slot_w-1:0] slot;
      logic [deg_w-1:0]  degree;
      slot   = slot_w'(rand_below(num_slots));
      degree = deg_w'(rand_below(32));
      expect_packet('0, pack_status(st_bad_op, degree, slot, op_w'(op)));
      push_token(header_word(op_w'(op), slot, degree));
   endtask

   task automatic random_command();
      int kind;
      kind = rand_below(20);
      if (kind < 8)
         store_poly(rand_below(num_slots), rand_below(max_degree + 1));
      else if (kind < 16)
         eval_poly(rand_below(num_slots), word_w'(rand_below(65536)));
      else if (kind == 16)
         store_poly(rand_below(num_slots), max_degree + 1 + rand_below(24));
      else if (kind == 17)
         issue_bad_opcode((rand_below(4) == 0) ? 2 : 4 + rand_below(252));
      else if (kind == 18)
         clear_slots();
      else
         eval_poly(rand_below(num_slots), word_w'(rand_below(16)));   // small x
   endtask

   task automatic check_packet();
      out_pkt_t want;
      checked++;
      assert (exp_q.size() > 0)
      else
      begin
         errors++;
         $display("[ERROR] %0t ns: packet %0d came out with no command left to match it",
                  $time, checked);
      end
      if (exp_q.size() > 0)
      begin
         want = exp_q.pop_front();
         assert (out == want)
         else
         begin
            errors++;
            $display("[ERROR] %0t ns: packet %0d result %h status %h, expected %h status %h",
                     $time, checked, out.result, out.status, want.result, want.status);
         end
      end
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < wait_limit)
      begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout at %0t ns, %0d packets never came out", $time, exp_q.size());
         hung = 1'b1;
      end
   endtask

   // out_ready changes on the falling edge, a packet seen here transfers on the next rise
   initial
   begin
      out_ready  = 1'b0;
      stall_seed = 38;
      forever
      begin
         @(negedge clk);
         if (rst === 1'b1 && hung === 1'b0)
         begin
            stall_bits = $random(stall_seed);
            out_ready  = (stall_bits[1:0] != 2'd0);
            if (out_valid && out_ready)
               check_packet();
         end
      end
   end

   initial
   begin
      int d;
      int i;
      seed      = 38;
      hung      = 1'b0;
      model_vld = '0;
      rst       = 1'b0;
      tok_valid = 1'b0;
      tok.value = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;

      eval_poly(0, word_w'(rand_below(65536)));   // slots never stored
      eval_poly(5, word_w'(rand_below(65536)));
      for (d = 0; d <= max_degree; d++)
      begin
         store_poly(d, d);
         eval_poly(d, word_w'(rand_below(65536)));
         pause_tokens(rand_below(3));
      end
      store_poly(3, max_degree);   // overwrite a slot twice
      eval_poly(3, word_w'(rand_below(65536)));
      store_poly(3, 2);
      eval_poly(3, word_w'(rand_below(65536)));
      store_poly(2, max_degree + 1);   // the next token must parse as a header
      store_poly(2, 31);
      eval_poly(2, word_w'(rand_below(65536)));
      issue_bad_opcode(2);
      issue_bad_opcode(4 + rand_below(252));
      clear_slots();
      for (d = 0; d < num_slots; d++)
         eval_poly(d, word_w'(rand_below(65536)));
      for (i = 0; i < random_cmds; i++)
      begin
         random_command();
         pause_tokens(rand_below(2));
      end
      pause_tokens(1);
      drain_outputs();
      pause_tokens(10);   // room for any stray packet

      $display("closing: %0d packets checked, %0d errors, %0d packets missing",
               checked, errors, exp_q.size());
      if (!hung && errors == 0 && exp_q.size() == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* list.f */
src/poly_cmd_pkg.sv
src/poly_pipe_pkg.sv
src/cmd_parser.sv
src/coef_bank.sv
src/horner_eval.sv
src/poly_engine.sv
dv/poly_engine_assert.sv
dv/poly_engine_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the poly_engine testbench with Verilator, pass or fail from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps -f list.f \
   --top-module poly_engine_tb --Mdir obj_dir -o poly_engine_sim

status=0
./obj_dir/poly_engine_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log || grep -q "%Error" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
